/* chipRegBridge.f */
+incdir+verilog
verilog/chipRegPkg.sv
verilog/regDecode.sv
verilog/regCycleSm.sv
verilog/regDataPath.sv
verilog/chipRegBridge.sv
testbench/chipsetModel.sv
testbench/chipRegBridgeTb.sv

/* testbench/chipRegBridgeTb.sv */
/*
 * Testbench top for the chip register bridge
 * Reads accesses from the testdata file, drives Wishbone, checks responses
 * Chipset protocol monitor and run watchdog
 */
`include "chipReg_config.svh"

module chipRegBridgeTb;
    timeunit 1ns;
    timeprecision 100ps;
    import chipRegPkg::*;

    logic    C3 = 1'b0;
    logic    RESETn, cyc, stb, we, ack, err;
    logic    regEnN, asN, dsEn, chipDataOe, dbrN;
    cpuAddrT adr;
    regDataT datW, datR, chipDataOut, chipDataIn;
    regAddrT chipAddr;

    // Test table from the data file
    logic [7:0] opTab [0:63];
    cpuAddrT    adrTab [0:63];
    regDataT    datTab [0:63];
    int         dmaTab [0:63];
    int         numTests, numRun, errors, checks, minReadLat;
    int         cycleCount, cycleLimit;
    bit         limitReady = 1'b0;
    // Chipset cycles issued, started and ended
    int         issued, started, done;
    logic       seenEnN = 1'b1;
    bit         isWrite [0:63];

    always #10 C3 = ~C3;

    chipRegBridge dut0 (.*);
    chipsetModel model0 (.*);

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        checks = checks + 1;
        if (got !== want) begin
            errors = errors + 1;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    task automatic loadTestData(output bit ok);
        int         fd;
        int         code;
        int         ch;
        int         n;
        logic [7:0] op;
        cpuAddrT    a;
        regDataT    d;
        ok = 1'b0;
        fd = $fopen("testbench/chipRegBridge_testdata.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            code = $fscanf(fd, " %c", op);
            while (code == 1 && ok) begin
                if (op == "#") begin
                    // Comment, skip the rest of the line
                    ch = 0;
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, "%h %h %d", a, d, n);
                    if (code != 3 || numTests == 64) begin
                        ok = 1'b0;
                    end else begin
                        opTab[numTests]  = op;
                        adrTab[numTests] = a;
                        datTab[numTests] = d;
                        dmaTab[numTests] = n;
                        numTests = numTests + 1;
                        if (op != "I") begin
                            cycleLimit = cycleLimit + 12 + n;
                        end
                    end
                end
                code = $fscanf(fd, " %c", op);
            end
            $fclose(fd);
        end
    endtask

    task automatic runAccess(input int i);
        int lat;
        int errBefore;
        int myNum;
        errBefore = errors;
        repeat ($urandom % 4) @(negedge C3);
        myNum = issued;
        if (opTab[i] != "E") begin
            isWrite[issued] = (opTab[i] == "W");
            model0.setDma(issued[5:0], dmaTab[i]);
            issued = issued + 1;
        end
        @(posedge C3);
        cyc  <= 1'b1;
        stb  <= 1'b1;
        we   <= (opTab[i] == "W");
        adr  <= adrTab[i];
        datW <= datTab[i];
        // Cycles counted from the edge that presents the strobe
        @(negedge C3);
        lat = 0;
        while (!(ack || err)) begin
            @(negedge C3);
            lat = lat + 1;
        end
        if (opTab[i] == "E") begin
            checkValue("err", err, 1);
            checkValue("err latency", lat, 1);
        end else begin
            checkValue("ack", ack, 1);
            if (opTab[i] == "R") begin
                checkValue("datR", datR, datTab[i]);
            end
            // Posted, so the chipset cycle is still open
            if (opTab[i] == "W" && done > myNum) begin
                errors = errors + 1;
                $display("Write to 0x%06h was acknowledged after its chipset cycle", adrTab[i]);
            end
        end
        if (opTab[i] == "R" && dmaTab[i] == 0 && lat < minReadLat) begin
            minReadLat = lat;
        end
        if (opTab[i] == "R" && dmaTab[i] > 0 && lat < minReadLat + dmaTab[i]) begin
            errors = errors + 1;
            $display("Read with %0d DMA cycles acked after only %0d cycles", dmaTab[i], lat);
        end
        @(posedge C3);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        @(negedge C3);
        numRun = numRun + 1;
        $display("Test %0d %c adr 0x%06h dma %0d latency %0d %s", i, opTab[i], adrTab[i],
                 dmaTab[i], lat, (errors == errBefore) ? "ok" : "error");
    endtask

    ////////////////////////////////////////////////////////////
    // Chipset protocol monitor
    ////////////////////////////////////////////////////////////

    always @(posedge C3) begin
        if (RESETn) begin
            if (seenEnN && !regEnN) begin
                started = started + 1;
                if (started > issued) begin
                    errors = errors + 1;
                    $display("Chipset cycle started without an in-window access");
                end
            end
            if (!seenEnN && regEnN) begin
                done = done + 1;
            end
            if (!asN && regEnN) begin
                errors = errors + 1;
                $display("asN low while regEnN high at cycle %0d", cycleCount);
            end
            // Data strobe only inside a register cycle
            if (dsEn && regEnN) begin
                errors = errors + 1;
                $display("dsEn high while regEnN high at cycle %0d", cycleCount);
            end
            if (chipDataOe && (started == 0 || !isWrite[started-1])) begin
                errors = errors + 1;
                $display("chipDataOe high outside a write cycle at cycle %0d", cycleCount);
            end
            seenEnN = regEnN;
        end
    end

    // Run limit from the test lengths
    initial begin
        cycleCount = 0;
        wait (limitReady);
        while (cycleCount < cycleLimit) begin
            @(posedge C3);
            cycleCount = cycleCount + 1;
        end
        $display("Timeout after %0d cycles, the bridge stopped answering", cycleLimit);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int unsigned seed;
        int          dummy;
        bit          ok;
        cpuAddrT     off;
        seed = 32'h83f8df29;
        dummy = $urandom(seed);
        RESETn = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        datW = '0;
        numTests = 0;
        numRun = 0;
        errors = 0;
        checks = 0;
        issued = 0;
        started = 0;
        done = 0;
        minReadLat = 1000;
        cycleLimit = 200;
        loadTestData(ok);
        if (!ok) begin
            $display("Could not read a valid testdata file");
            $display("TB FAILED");
            $finish;
        end else begin
            limitReady = 1'b1;
            repeat (16) @(posedge C3);
            RESETn <= 1'b1;
            @(negedge C3);
            // Model preloads first, then the accesses in file order
            for (int i = 0; i < numTests; i++) begin
                if (opTab[i] == "I") begin
                    off = adrTab[i] - cpuAddrT'(`CHIP_REG_BASE);
                    model0.preload(off[7:0], datTab[i]);
                end
            end
            for (int i = 0; i < numTests; i++) begin
                if (opTab[i] != "I") begin
                    runAccess(i);
                end
            end
            // Drain posted writes
            while (done != issued) @(negedge C3);
            repeat (2) @(negedge C3);
            checkValue("asN", asN, 1);
            checkValue("regEnN", regEnN, 1);
            checkValue("cycles started", started, issued);
            checkValue("minimum read latency", minReadLat, 7);
            $display("Tests %0d, checks %0d, errors %0d", numRun, checks, errors);
            if (errors == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

/* testbench/chipRegBridge_testdata.txt */
# op adr data dma; I preloads the model, R reads and expects data, W writes, E expects err
# adr is the CPU word address in hex, data in hex, dma the number of DMA busy cycles
I 6ff802 1234 0
I 6ff810 beef 0
I 6ff8ff 8001 0
R 6ff802 1234 0
R 6ff810 beef 0
R 6ff8ff 8001 0
R 6ff805 fa05 0
W 6ff820 a5a5 0
R 6ff820 a5a5 0
W 6ff821 0f0f 2
R 6ff821 0f0f 0
R 6ff802 1234 3
R 6ff810 beef 9
E 6ff900 0000 0
E 6ff7ff 0000 0
W 6ff830 1111 0
W 6ff831 2222 0
W 6ff832 3333 4
R 6ff830 1111 0
R 6ff832 3333 1
E 000100 0000 0
W 6ff802 c0de 0
R 6ff802 c0de 5
E 7fffff 0000 0

/* testbench/chipsetModel.sv */
/*
 * Behavioral custom chip register file
 * Answers register strobes, raises DMA bus requests on command
 */
module chipsetModel (
    input  logic                C3,
    input  logic                RESETn,
    input  logic                regEnN,
    input  logic                asN,
    input  logic                dsEn,
    input  chipRegPkg::regAddrT chipAddr,
    input  chipRegPkg::regDataT chipDataOut,
    input  logic                chipDataOe,
    output chipRegPkg::regDataT chipDataIn,
    output logic                dbrN
);
    timeunit 1ns;
    timeprecision 100ps;
    import chipRegPkg::*;

    regDataT    regs [0:255];
    // DMA busy cycles, one entry per chipset cycle
    logic [7:0] dmaLen [0:63];
    logic [5:0] cycleIdx;
    logic [7:0] used;
    logic       regEnNd;
    logic       cycleOn;

    // Fill pattern from the whole register index
    initial begin
        logic [8:0] k;
        for (k = 0; k < 256; k = k + 1) begin
            regs[k[7:0]] = {~k[7:0], k[7:0]};
        end
        for (k = 0; k < 64; k = k + 1) begin
            dmaLen[k[5:0]] = 8'd0;
        end
    end

    task automatic preload(input logic [7:0] idx, input regDataT val);
        regs[idx] = val;
    endtask

    task automatic setDma(input logic [5:0] idx, input int n);
        dmaLen[idx] = n[7:0];
    endtask

    assign cycleOn = (regEnN === 1'b0);

    // Agnus owns the bus from regEnN fall for the commanded cycles
    assign dbrN = !(cycleOn && (used < dmaLen[cycleIdx]));

    // Read data only inside a read data strobe
    assign chipDataIn = (cycleOn && dsEn === 1'b1 && chipDataOe === 1'b0) ?
                        regs[chipAddr[8:1]] : 16'h0000;

    always @(posedge C3) begin
        if (!RESETn) begin
            cycleIdx <= 6'd0;
            used     <= 8'd0;
            regEnNd  <= 1'b1;
        end else begin
            regEnNd <= regEnN;
            // End of cycle, move to the next DMA entry
            if (regEnN && !regEnNd) begin
                cycleIdx <= cycleIdx + 6'd1;
                used     <= 8'd0;
            end else if (!regEnN && used < dmaLen[cycleIdx]) begin
                used <= used + 8'd1;
            end
            // Write strobe
            if (!regEnN && !asN && dsEn && chipDataOe) begin
                regs[chipAddr[8:1]] <= chipDataOut;
            end
        end
    end

endmodule

/* verilog/chipRegBridge.sv */
/*
 * Wishbone to custom chip register bridge top level
 * Decode, cycle sequencer and data path stages
 */
module chipRegBridge (
    input  logic                C3,
    input  logic                RESETn,
    // Wishbone classic slave
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  chipRegPkg::cpuAddrT adr,
    input  chipRegPkg::regDataT datW,
    output logic                ack,
    output logic                err,
    output chipRegPkg::regDataT datR,
    // Custom chip register bus
    output logic                regEnN,
    output logic                asN,
    output logic                dsEn,
    output chipRegPkg::regAddrT chipAddr,
    output chipRegPkg::regDataT chipDataOut,
    output logic                chipDataOe,
    input  chipRegPkg::regDataT chipDataIn,
    input  logic                dbrN
);
    import chipRegPkg::*;

    // Decode to sequencer
    logic    reqValid;
    logic    reqTake;
    regReqT  req;
    // Sequencer to data path
    regDataT wrData;
    logic    rnw;
    logic    latchRead;
    // Data path back to decode
    logic    rdAck;
    regDataT rdData;

    regDecode decode0 (
        .C3(C3), .RESETn(RESETn),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW),
        .reqTake(reqTake), .rdAck(rdAck), .rdData(rdData),
        .ack(ack), .err(err), .datR(datR),
        .reqValid(reqValid), .req(req)
    );

    regCycleSm cycleSm0 (
        .C3(C3), .RESETn(RESETn),
        .reqValid(reqValid), .req(req), .dbrN(dbrN),
        .reqTake(reqTake), .regEnN(regEnN), .asN(asN), .dsEn(dsEn),
        .chipAddr(chipAddr), .wrData(wrData), .rnw(rnw), .latchRead(latchRead)
    );

    regDataPath dataPath0 (
        .C3(C3), .RESETn(RESETn),
        .regEnN(regEnN), .dsEn(dsEn), .rnw(rnw), .wrData(wrData),
        .latchRead(latchRead), .chipDataIn(chipDataIn),
        .chipDataOut(chipDataOut), .chipDataOe(chipDataOe),
        .rdAck(rdAck), .rdData(rdData)
    );

endmodule

/* verilog/chipRegPkg.sv */
/*
 * Shared types of the chip register bridge
 * Address and data vectors, request struct, 68000 cycle states
 */
`include "chipReg_config.svh"

package chipRegPkg;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    // CPU side word address
    typedef logic [`CPU_ADDR_W-1:0] cpuAddrT;

    // Register offset as a byte address, bit 0 always zero
    typedef logic [8:0] regAddrT;

    // One chipset register word
    typedef logic [15:0] regDataT;

    ////////////////////////////////////////////////////////////
    // Request handed from decode to the sequencer
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        regAddrT addr;
        regDataT wdata;
        // High for a read
        logic    rnw;
    } regReqT;

    ////////////////////////////////////////////////////////////
    // MC68000 bus states, one C3 edge per half state
    ////////////////////////////////////////////////////////////

    // S3 and S6 have no action of their own here and are folded away
    typedef enum logic [2:0] {
        IDLE = 3'd0,
        S1   = 3'd1,
        S2   = 3'd2,
        S4   = 3'd3,
        S5   = 3'd4,
        S7   = 3'd5
    } cycStateT;

endpackage

/* verilog/chipReg_config.svh */
/*
 * Build-time settings for the chip register bridge
 * Register window placement, CPU address width, write posting
 */
`ifndef CHIPREG_CONFIG_SVH
`define CHIPREG_CONFIG_SVH

// CPU word address width, 16-bit words
`define CPU_ADDR_W 23

// Custom chip window, byte address 0xDFF000 as a word address
`define CHIP_REG_BASE 23'h6FF800

// Number of 16-bit registers decoded in the window
`define CHIP_REG_WORDS 256

// 1 acks writes at capture, 0 waits for the end of the chipset cycle
`define POSTED_WRITES 1

`endif

/* verilog/regCycleSm.sv */
/*
 * MC68000 compatible register cycle sequencer
 * dbrN synchronizer, S4 wait states, early read latch at S5
 */
module regCycleSm (
    input  logic                C3,
    input  logic                RESETn,
    input  logic                reqValid,
    input  chipRegPkg::regReqT  req,
    input  logic                dbrN,
    output logic                reqTake,
    output logic                regEnN,
    output logic                asN,
    output logic                dsEn,
    output chipRegPkg::regAddrT chipAddr,
    output chipRegPkg::regDataT wrData,
    output logic                rnw,
    output logic                latchRead
);
    import chipRegPkg::*;

    cycStateT   state;
    // Request owned by the running bus cycle
    regReqT     curReq;
    logic [1:0] dbrSync;
    logic       dmaFree;

    ////////////////////////////////////////////////////////////
    // DMA request synchronizer
    ////////////////////////////////////////////////////////////

    // Two flops, idle value is no request
    always_ff @(posedge C3) begin
        if (!RESETn) begin
            dbrSync <= 2'b11;
        end else begin
            dbrSync <= {dbrSync[0], dbrN};
        end
    end

    assign dmaFree = dbrSync[1];

    ////////////////////////////////////////////////////////////
    // Request hand-off
    ////////////////////////////////////////////////////////////

    // Pulses in the last IDLE cycle
    assign reqTake = (state == IDLE) && reqValid;

    // Registered as the cycle enters S1
    always_ff @(posedge C3) begin
        if (reqTake) begin
            curReq <= req;
        end
    end

    assign chipAddr = curReq.addr;
    assign wrData   = curReq.wdata;
    assign rnw      = curReq.rnw;

    ////////////////////////////////////////////////////////////
    // 68000 state sequence
    ////////////////////////////////////////////////////////////

    always_ff @(posedge C3) begin
        if (!RESETn) begin
            state  <= IDLE;
            regEnN <= 1'b1;
            asN    <= 1'b1;
            dsEn   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (reqValid) begin
                        // S1, register space select
                        regEnN <= 1'b0;
                        state  <= S1;
                    end
                end
                S1: begin
                    // S2, address strobe; reads open the buffers early
                    asN   <= 1'b0;
                    dsEn  <= curReq.rnw;
                    state <= S2;
                end
                S2: begin
                    // S4, data strobe for both directions
                    dsEn  <= 1'b1;
                    state <= S4;
                end
                S4: begin
                    // Wait states while Agnus owns the bus
                    if (dmaFree) begin
                        state <= S5;
                    end
                end
                S5: begin
                    // S7, end of cycle, read data already latched
                    asN    <= 1'b1;
                    regEnN <= 1'b1;
                    dsEn   <= 1'b0;
                    state  <= S7;
                end
                S7: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Early read latch, as the original machines do
    assign latchRead = (state == S5) && curReq.rnw;

    ////////////////////////////////////////////////////////////
    // Bus protocol checks
    ////////////////////////////////////////////////////////////

    asInsideRegEn: assert property (@(posedge C3) disable iff (!RESETn) !asN |-> !regEnN);

    dsIdleLow: assert property (@(posedge C3) disable iff (!RESETn) (state == IDLE) |-> !dsEn);

endmodule

/* verilog/regDataPath.sv */
/*
 * Chipset data buffers
 * Write data drive, S5 read latch, response pulse to decode
 */
`include "chipReg_config.svh"

module regDataPath (
    input  logic                C3,
    input  logic                RESETn,
    input  logic                regEnN,
    input  logic                dsEn,
    input  logic                rnw,
    input  chipRegPkg::regDataT wrData,
    input  logic                latchRead,
    input  chipRegPkg::regDataT chipDataIn,
    output chipRegPkg::regDataT chipDataOut,
    output logic                chipDataOe,
    output logic                rdAck,
    output chipRegPkg::regDataT rdData
);

    localparam bit PostWr = (`POSTED_WRITES != 0);

    // regEnN one cycle back, for the end of cycle edge
    logic regEnNd;
    logic wrDone;

    ////////////////////////////////////////////////////////////
    // Write buffer
    ////////////////////////////////////////////////////////////

    // Drive only inside a write data strobe
    assign chipDataOe = !regEnN && dsEn && !rnw;

    // Stable from S2 on, strobe opens at S4
    always_ff @(posedge C3) begin
        chipDataOut <= wrData;
    end

    ////////////////////////////////////////////////////////////
    // Read latch and response
    ////////////////////////////////////////////////////////////

    // Unposted writes complete when regEnN returns high at S7
    assign wrDone = !PostWr && !rnw && regEnN && !regEnNd;

    always_ff @(posedge C3) begin
        if (!RESETn) begin
            rdAck   <= 1'b0;
            regEnNd <= 1'b1;
        end else begin
            rdAck   <= latchRead || wrDone;
            regEnNd <= regEnN;
        end
    end

    // Sampled at the S5 to S7 edge
    always_ff @(posedge C3) begin
        if (latchRead) begin
            rdData <= chipDataIn;
        end
    end

endmodule

/* verilog/regDecode.sv */
/*
 * Wishbone classic slave front stage
 * Window decode, error response, one-entry request buffer
 * Posted write ack and read data return
 */
`include "chipReg_config.svh"

module regDecode (
    input  logic                C3,
    input  logic                RESETn,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  chipRegPkg::cpuAddrT adr,
    input  chipRegPkg::regDataT datW,
    input  logic                reqTake,
    input  logic                rdAck,
    input  chipRegPkg::regDataT rdData,
    output logic                ack,
    output logic                err,
    output chipRegPkg::regDataT datR,
    output logic                reqValid,
    output chipRegPkg::regReqT  req
);
    import chipRegPkg::*;

    localparam bit PostWr = (`POSTED_WRITES != 0);

    cpuAddrT offset;
    logic    inWin;
    logic    newStb;
    logic    capture;
    logic    needResp;
    // Master is parked waiting for rdAck
    logic    respPend;

    ////////////////////////////////////////////////////////////
    // Window decode
    ////////////////////////////////////////////////////////////

    assign offset = adr - cpuAddrT'(`CHIP_REG_BASE);
    assign inWin  = (adr >= cpuAddrT'(`CHIP_REG_BASE)) && (offset < `CHIP_REG_WORDS);

    // Strobe not yet answered or captured
    assign newStb  = cyc && stb && !ack && !err && !respPend;
    // Back-pressure while the buffer is full
    assign capture = newStb && inWin && !reqValid;
    // Reads always, writes only when not posted
    assign needResp = !we || !PostWr;

    always_ff @(posedge C3) begin
        if (!RESETn) begin
            ack      <= 1'b0;
            err      <= 1'b0;
            reqValid <= 1'b0;
            respPend <= 1'b0;
        end else begin
            // Outside the window, answer with err and start nothing
            err <= newStb && !inWin;
            ack <= (capture && !needResp) || (respPend && rdAck);

            if (capture) begin
                reqValid <= 1'b1;
            end else if (reqTake) begin
                reqValid <= 1'b0;
            end

            if (capture && needResp) begin
                respPend <= 1'b1;
            end else if (rdAck) begin
                respPend <= 1'b0;
            end
        end
    end

    // Request payload, byte offset for the chipset
    always_ff @(posedge C3) begin
        if (capture) begin
            req.addr  <= regAddrT'({offset[7:0], 1'b0});
            req.wdata <= datW;
            req.rnw   <= !we;
        end
        if (rdAck) begin
            datR <= rdData;
        end
    end

    // One response per strobe
    ackErrExcl: assert property (@(posedge C3) disable iff (!RESETn) !(ack && err));

endmodule
